// ==== rtl/axi_pkg.sv ====
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 8;
    // Burst carries arlen+1 beats
    localparam int LEN_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // Read address beat, 48 bits
    typedef struct packed {
        addr_t addr;
        id_t   id;
        len_t  len;
    } ar_payload_t;

    // Read data beat, 43 bits
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_payload_t;

endpackage

// ==== rtl/xbar_map_pkg.sv ====
package xbar_map_pkg;

    localparam int N_MASTERS = 2;
    localparam int N_SLAVES  = 2;

    // Slave 1 region starts at zero
    // Anything above goes to slave 2 with this span removed
    localparam logic [31:0] S1_SPAN = 32'h8000_0000;

    // One-hot owner of a slave port
    // Bit 0 is master 1 and bit 1 is master 2
    // All zero when the slave is idle
    typedef logic [N_MASTERS-1:0] grant_t;

endpackage

// ==== rtl/ar_addr_decoder.sv ====
module ar_addr_decoder
    import axi_pkg::*;
    import xbar_map_pkg::*;
(
    input  logic  i_arvalid,
    input  addr_t i_araddr,
    output logic  o_sel_s1,
    output logic  o_sel_s2,
    output addr_t o_addr_s1,
    output addr_t o_addr_s2
);

    logic in_s1;

    // Lower region belongs to slave 1
    assign in_s1 = (i_araddr < S1_SPAN);

    // Only one select can be high, and only with a live request
    assign o_sel_s1 = i_arvalid & in_s1;
    assign o_sel_s2 = i_arvalid & ~in_s1;

    // Slave-local addresses
    assign o_addr_s1 = i_araddr;
    assign o_addr_s2 = i_araddr - S1_SPAN;

endmodule

// ==== rtl/read_arbiter.sv ====
module read_arbiter
    import xbar_map_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [N_MASTERS-1:0] i_req,
    input  logic                 i_ar_done,
    input  logic                 i_r_last_done,
    output grant_t               o_grant
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t state;
    // Winner of the last contested choice was master 2
    logic   last_m2;
    grant_t pick;

    // Round-robin between two live requests
    always_comb begin
        if (i_req == 2'b11) begin
            pick = last_m2 ? 2'b01 : 2'b10;
        end else begin
            pick = i_req;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= ST_IDLE;
            o_grant <= '0;
            // Master 1 goes first out of reset
            last_m2 <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (|i_req) begin
                        state   <= ST_ADDR;
                        o_grant <= pick;
                        if (i_req == 2'b11) begin
                            last_m2 <= pick[1];
                        end
                    end
                end
                ST_ADDR: begin
                    // AR accepted by the slave, wait for the burst
                    if (i_ar_done) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    // Grant is held until the rlast beat moves
                    if (i_r_last_done) begin
                        state   <= ST_IDLE;
                        o_grant <= '0;
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    o_grant <= '0;
                end
            endcase
        end
    end

endmodule

// ==== rtl/channel_mux.sv ====
module channel_mux
    import axi_pkg::*;
    import xbar_map_pkg::*;
#(
    parameter type payload_t = ar_payload_t
) (
    input  grant_t     i_sel,
    input  logic [1:0] i_valid,
    input  payload_t   i_payload [2],
    output logic       o_valid,
    output payload_t   o_payload
);

    always_comb begin
        // Quiet output when nothing is selected
        o_valid   = 1'b0;
        o_payload = '0;
        case (i_sel)
            2'b01: begin
                o_valid   = i_valid[0];
                o_payload = i_payload[0];
            end
            2'b10: begin
                o_valid   = i_valid[1];
                o_payload = i_payload[1];
            end
            default: begin
                o_valid   = 1'b0;
                o_payload = '0;
            end
        endcase
    end

endmodule

// ==== rtl/axi_read_xbar.sv ====
module axi_read_xbar
    import axi_pkg::*;
    import xbar_map_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    // Master 1
    input  logic  i_m1_arvalid,
    output logic  o_m1_arready,
    input  addr_t i_m1_araddr,
    input  id_t   i_m1_arid,
    input  len_t  i_m1_arlen,
    output logic  o_m1_rvalid,
    input  logic  i_m1_rready,
    output id_t   o_m1_rid,
    output data_t o_m1_rdata,
    output resp_t o_m1_rresp,
    output logic  o_m1_rlast,

    // Master 2
    input  logic  i_m2_arvalid,
    output logic  o_m2_arready,
    input  addr_t i_m2_araddr,
    input  id_t   i_m2_arid,
    input  len_t  i_m2_arlen,
    output logic  o_m2_rvalid,
    input  logic  i_m2_rready,
    output id_t   o_m2_rid,
    output data_t o_m2_rdata,
    output resp_t o_m2_rresp,
    output logic  o_m2_rlast,

    // Slave 1
    output logic  o_s1_arvalid,
    input  logic  i_s1_arready,
    output addr_t o_s1_araddr,
    output id_t   o_s1_arid,
    output len_t  o_s1_arlen,
    input  logic  i_s1_rvalid,
    output logic  o_s1_rready,
    input  id_t   i_s1_rid,
    input  data_t i_s1_rdata,
    input  resp_t i_s1_rresp,
    input  logic  i_s1_rlast,

    // Slave 2
    output logic  o_s2_arvalid,
    input  logic  i_s2_arready,
    output addr_t o_s2_araddr,
    output id_t   o_s2_arid,
    output len_t  o_s2_arlen,
    input  logic  i_s2_rvalid,
    output logic  o_s2_rready,
    input  id_t   i_s2_rid,
    input  data_t i_s2_rdata,
    input  resp_t i_s2_rresp,
    input  logic  i_s2_rlast
);

    logic sel_m1_s1;
    logic sel_m1_s2;
    logic sel_m2_s1;
    logic sel_m2_s2;
    addr_t addr_m1_s1;
    addr_t addr_m1_s2;
    addr_t addr_m2_s1;
    addr_t addr_m2_s2;

    grant_t grant_s1;
    grant_t grant_s2;
    // Index 0 is slave 1
    logic [N_SLAVES-1:0] ar_done;
    logic [N_SLAVES-1:0] r_last_done;

    ar_payload_t ar_in_s1 [2];
    ar_payload_t ar_in_s2 [2];
    ar_payload_t ar_out_s1;
    ar_payload_t ar_out_s2;
    r_payload_t  r_in [2];
    r_payload_t  r_out_m1;
    r_payload_t  r_out_m2;

    ar_addr_decoder dec_m1 (
        .i_arvalid (i_m1_arvalid),
        .i_araddr  (i_m1_araddr),
        .o_sel_s1  (sel_m1_s1),
        .o_sel_s2  (sel_m1_s2),
        .o_addr_s1 (addr_m1_s1),
        .o_addr_s2 (addr_m1_s2)
    );

    ar_addr_decoder dec_m2 (
        .i_arvalid (i_m2_arvalid),
        .i_araddr  (i_m2_araddr),
        .o_sel_s1  (sel_m2_s1),
        .o_sel_s2  (sel_m2_s2),
        .o_addr_s1 (addr_m2_s1),
        .o_addr_s2 (addr_m2_s2)
    );

    // Handshakes seen at the slave ports end the grant phases
    assign ar_done[0]     = o_s1_arvalid & i_s1_arready;
    assign ar_done[1]     = o_s2_arvalid & i_s2_arready;
    assign r_last_done[0] = i_s1_rvalid & o_s1_rready & i_s1_rlast;
    assign r_last_done[1] = i_s2_rvalid & o_s2_rready & i_s2_rlast;

    read_arbiter arb_s1 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req         ({sel_m2_s1, sel_m1_s1}),
        .i_ar_done     (ar_done[0]),
        .i_r_last_done (r_last_done[0]),
        .o_grant       (grant_s1)
    );

    read_arbiter arb_s2 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req         ({sel_m2_s2, sel_m1_s2}),
        .i_ar_done     (ar_done[1]),
        .i_r_last_done (r_last_done[1]),
        .o_grant       (grant_s2)
    );

    // AR payloads carry the slave-local address
    assign ar_in_s1[0] = '{addr: addr_m1_s1, id: i_m1_arid, len: i_m1_arlen};
    assign ar_in_s1[1] = '{addr: addr_m2_s1, id: i_m2_arid, len: i_m2_arlen};
    assign ar_in_s2[0] = '{addr: addr_m1_s2, id: i_m1_arid, len: i_m1_arlen};
    assign ar_in_s2[1] = '{addr: addr_m2_s2, id: i_m2_arid, len: i_m2_arlen};

    channel_mux #(.payload_t(ar_payload_t)) ar_mux_s1 (
        .i_sel     (grant_s1),
        .i_valid   ({sel_m2_s1, sel_m1_s1}),
        .i_payload (ar_in_s1),
        .o_valid   (o_s1_arvalid),
        .o_payload (ar_out_s1)
    );

    channel_mux #(.payload_t(ar_payload_t)) ar_mux_s2 (
        .i_sel     (grant_s2),
        .i_valid   ({sel_m2_s2, sel_m1_s2}),
        .i_payload (ar_in_s2),
        .o_valid   (o_s2_arvalid),
        .o_payload (ar_out_s2)
    );

    assign o_s1_araddr = ar_out_s1.addr;
    assign o_s1_arid   = ar_out_s1.id;
    assign o_s1_arlen  = ar_out_s1.len;
    assign o_s2_araddr = ar_out_s2.addr;
    assign o_s2_arid   = ar_out_s2.id;
    assign o_s2_arlen  = ar_out_s2.len;

    // Only the granted master sees the slave's arready
    assign o_m1_arready = (grant_s1[0] & i_s1_arready) | (grant_s2[0] & i_s2_arready);
    assign o_m2_arready = (grant_s1[1] & i_s1_arready) | (grant_s2[1] & i_s2_arready);

    // Idle slave gets rready low
    assign o_s1_rready = (grant_s1[0] & i_m1_rready) | (grant_s1[1] & i_m2_rready);
    assign o_s2_rready = (grant_s2[0] & i_m1_rready) | (grant_s2[1] & i_m2_rready);

    assign r_in[0] = '{id: i_s1_rid, data: i_s1_rdata, resp: i_s1_rresp, last: i_s1_rlast};
    assign r_in[1] = '{id: i_s2_rid, data: i_s2_rdata, resp: i_s2_rresp, last: i_s2_rlast};

    // Each master listens to the slave whose grant names it
    channel_mux #(.payload_t(r_payload_t)) r_mux_m1 (
        .i_sel     ({grant_s2[0], grant_s1[0]}),
        .i_valid   ({i_s2_rvalid, i_s1_rvalid}),
        .i_payload (r_in),
        .o_valid   (o_m1_rvalid),
        .o_payload (r_out_m1)
    );

    channel_mux #(.payload_t(r_payload_t)) r_mux_m2 (
        .i_sel     ({grant_s2[1], grant_s1[1]}),
        .i_valid   ({i_s2_rvalid, i_s1_rvalid}),
        .i_payload (r_in),
        .o_valid   (o_m2_rvalid),
        .o_payload (r_out_m2)
    );

    assign o_m1_rid   = r_out_m1.id;
    assign o_m1_rdata = r_out_m1.data;
    assign o_m1_rresp = r_out_m1.resp;
    assign o_m1_rlast = r_out_m1.last;
    assign o_m2_rid   = r_out_m2.id;
    assign o_m2_rdata = r_out_m2.data;
    assign o_m2_rresp = r_out_m2.resp;
    assign o_m2_rlast = r_out_m2.last;

endmodule

// ==== tests/axi_read_xbar_props.sv ====
module axi_read_xbar_props
    import axi_pkg::*;
    import xbar_map_pkg::*;
(
    input logic   i_clk,
    input logic   i_rst,
    input grant_t i_grant_s1,
    input grant_t i_grant_s2,
    input logic   i_s1_arvalid,
    input logic   i_s2_arvalid,
    input logic   i_m1_rvalid,
    input logic   i_m1_rready,
    input data_t  i_m1_rdata,
    input logic   i_m2_rvalid,
    input logic   i_m2_rready,
    input data_t  i_m2_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // Count of property failures
    int assert_fails = 0;

    a_grant_s1_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(i_grant_s1))
        else begin
            assert_fails++;
            $error("grant_s1 holds more than one master");
        end
    a_grant_s2_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(i_grant_s2))
        else begin
            assert_fails++;
            $error("grant_s2 holds more than one master");
        end

    // A slave only sees a request that an arbiter has granted
    a_s1_arvalid_granted: assert property (@(posedge i_clk) disable iff (i_rst)
        i_s1_arvalid |-> (i_grant_s1 != '0))
        else begin
            assert_fails++;
            $error("s1 arvalid high with no grant");
        end
    a_s2_arvalid_granted: assert property (@(posedge i_clk) disable iff (i_rst)
        i_s2_arvalid |-> (i_grant_s2 != '0))
        else begin
            assert_fails++;
            $error("s2 arvalid high with no grant");
        end

    // Stalled beat keeps its data on the way back to the master
    a_m1_rdata_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_m1_rvalid && !i_m1_rready) |=> (i_m1_rvalid && $stable(i_m1_rdata)))
        else begin
            assert_fails++;
            $error("m1 rdata changed while stalled");
        end
    a_m2_rdata_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_m2_rvalid && !i_m2_rready) |=> (i_m2_rvalid && $stable(i_m2_rdata)))
        else begin
            assert_fails++;
            $error("m2 rdata changed while stalled");
        end

endmodule

// ==== tests/tb_axi_read_xbar.sv ====
// Simple AXI read slave, beat k returns local address plus k
module read_slave
    import axi_pkg::*;
    import xbar_map_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_arvalid,
    output logic  o_arready,
    input  addr_t i_araddr,
    input  id_t   i_arid,
    input  len_t  i_arlen,
    output logic  o_rvalid,
    input  logic  i_rready,
    output id_t   o_rid,
    output data_t o_rdata,
    output resp_t o_rresp,
    output logic  o_rlast
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        int    delay;
        addr_t addr;
        id_t   id;
        len_t  len;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rid     = '0;
        o_rdata   = '0;
        o_rresp   = RESP_OKAY;
        o_rlast   = 1'b0;
        forever begin
            @(negedge i_clk);
            if (!i_rst && i_arvalid) begin
                delay = $urandom_range(3);
                repeat (delay) @(negedge i_clk);
                o_arready = 1'b1;
                @(posedge i_clk);
                addr = i_araddr;
                id   = i_arid;
                len  = i_arlen;
                @(negedge i_clk);
                o_arready = 1'b0;
                for (int k = 0; k <= int'(len); k++) begin
                    o_rvalid = 1'b1;
                    o_rid    = id;
                    o_rdata  = addr + data_t'(k);
                    o_rlast  = (k == int'(len));
                    // Hold the beat until the master takes it
                    do @(posedge i_clk); while (!i_rready);
                    @(negedge i_clk);
                end
                o_rvalid = 1'b0;
                o_rlast  = 1'b0;
            end
        end
    end

endmodule

module tb_axi_read_xbar
    import axi_pkg::*;
    import xbar_map_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Six short tests need a few hundred cycles at most
    localparam int MAX_CYCLES = 4000;

    logic  clk = 1'b0;
    logic  rst;
    int    cycles;
    int    errors;
    int    checks;
    int    tests_run;
    time   ar_time [2];
    time   done_time [2];

    // Index 0 is m1 or s1
    logic  m_arvalid [2];
    logic  m_arready [2];
    addr_t m_araddr [2];
    id_t   m_arid [2];
    len_t  m_arlen [2];
    logic  m_rvalid [2];
    logic  m_rready [2];
    id_t   m_rid [2];
    data_t m_rdata [2];
    resp_t m_rresp [2];
    logic  m_rlast [2];
    logic  s_arvalid [2];
    logic  s_arready [2];
    addr_t s_araddr [2];
    id_t   s_arid [2];
    len_t  s_arlen [2];
    logic  s_rvalid [2];
    logic  s_rready [2];
    id_t   s_rid [2];
    data_t s_rdata [2];
    resp_t s_rresp [2];
    logic  s_rlast [2];

    always #5 clk = ~clk;

    axi_read_xbar uut (
        .i_clk (clk), .i_rst (rst),
        .i_m1_arvalid (m_arvalid[0]), .o_m1_arready (m_arready[0]),
        .i_m1_araddr (m_araddr[0]), .i_m1_arid (m_arid[0]), .i_m1_arlen (m_arlen[0]),
        .o_m1_rvalid (m_rvalid[0]), .i_m1_rready (m_rready[0]), .o_m1_rid (m_rid[0]),
        .o_m1_rdata (m_rdata[0]), .o_m1_rresp (m_rresp[0]), .o_m1_rlast (m_rlast[0]),
        .i_m2_arvalid (m_arvalid[1]), .o_m2_arready (m_arready[1]),
        .i_m2_araddr (m_araddr[1]), .i_m2_arid (m_arid[1]), .i_m2_arlen (m_arlen[1]),
        .o_m2_rvalid (m_rvalid[1]), .i_m2_rready (m_rready[1]), .o_m2_rid (m_rid[1]),
        .o_m2_rdata (m_rdata[1]), .o_m2_rresp (m_rresp[1]), .o_m2_rlast (m_rlast[1]),
        .o_s1_arvalid (s_arvalid[0]), .i_s1_arready (s_arready[0]),
        .o_s1_araddr (s_araddr[0]), .o_s1_arid (s_arid[0]), .o_s1_arlen (s_arlen[0]),
        .i_s1_rvalid (s_rvalid[0]), .o_s1_rready (s_rready[0]), .i_s1_rid (s_rid[0]),
        .i_s1_rdata (s_rdata[0]), .i_s1_rresp (s_rresp[0]), .i_s1_rlast (s_rlast[0]),
        .o_s2_arvalid (s_arvalid[1]), .i_s2_arready (s_arready[1]),
        .o_s2_araddr (s_araddr[1]), .o_s2_arid (s_arid[1]), .o_s2_arlen (s_arlen[1]),
        .i_s2_rvalid (s_rvalid[1]), .o_s2_rready (s_rready[1]), .i_s2_rid (s_rid[1]),
        .i_s2_rdata (s_rdata[1]), .i_s2_rresp (s_rresp[1]), .i_s2_rlast (s_rlast[1])
    );

    for (genvar i = 0; i < 2; i++) begin : g_slave
        read_slave slave (
            .i_clk (clk), .i_rst (rst),
            .i_arvalid (s_arvalid[i]), .o_arready (s_arready[i]),
            .i_araddr (s_araddr[i]), .i_arid (s_arid[i]), .i_arlen (s_arlen[i]),
            .o_rvalid (s_rvalid[i]), .i_rready (s_rready[i]), .o_rid (s_rid[i]),
            .o_rdata (s_rdata[i]), .o_rresp (s_rresp[i]), .o_rlast (s_rlast[i])
        );
    end

    bind axi_read_xbar axi_read_xbar_props props (
        .i_clk (i_clk), .i_rst (i_rst),
        .i_grant_s1 (grant_s1), .i_grant_s2 (grant_s2),
        .i_s1_arvalid (o_s1_arvalid), .i_s2_arvalid (o_s2_arvalid),
        .i_m1_rvalid (o_m1_rvalid), .i_m1_rready (i_m1_rready), .i_m1_rdata (o_m1_rdata),
        .i_m2_rvalid (o_m2_rvalid), .i_m2_rready (i_m2_rready), .i_m2_rdata (o_m2_rdata)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_grant_idle(input string name, input grant_t got);
        checks++;
        if (got !== '0) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, grant_t'(0));
        end
    endtask

    task automatic check_order(input string what, input bit ok);
        checks++;
        if (!ok) begin
            errors++;
            $display("Ordering error: %s", what);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    // One full read on master m toward slave s, with optional random rready stalls
    task automatic run_read(input int m, input int s, input addr_t addr,
                            input addr_t local_addr, input id_t id, input len_t len,
                            input bit stall);
        int    k;
        string tag;
        tag = $sformatf("m%0d", m + 1);
        @(negedge clk);
        m_arvalid[m] = 1'b1;
        m_araddr[m]  = addr;
        m_arid[m]    = id;
        m_arlen[m]   = len;
        do @(posedge clk); while (!m_arready[m]);
        ar_time[m] = $time;
        check_addr($sformatf("s%0d_araddr", s + 1), s_araddr[s], local_addr);
        check_id($sformatf("s%0d_arid", s + 1), s_arid[s], id);
        check_len($sformatf("s%0d_arlen", s + 1), s_arlen[s], len);
        @(negedge clk);
        m_arvalid[m] = 1'b0;
        k = 0;
        while (k <= int'(len)) begin
            m_rready[m] = stall ? ($urandom_range(2) != 0) : 1'b1;
            @(posedge clk);
            // Granted master's rready reaches the slave unchanged
            check_flag($sformatf("s%0d_rready", s + 1), s_rready[s], m_rready[m]);
            if (m_rvalid[m] && m_rready[m]) begin
                check_data({tag, "_rdata"}, m_rdata[m], local_addr + data_t'(k));
                check_id({tag, "_rid"}, m_rid[m], id);
                check_resp({tag, "_rresp"}, m_rresp[m], RESP_OKAY);
                check_flag({tag, "_rlast"}, m_rlast[m], k == int'(len));
                k++;
            end
            @(negedge clk);
        end
        m_rready[m] = 1'b0;
        done_time[m] = $time;
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        for (int i = 0; i < 2; i++) begin
            check_flag($sformatf("s%0d_arvalid", i + 1), s_arvalid[i], 1'b0);
            check_flag($sformatf("s%0d_rready", i + 1), s_rready[i], 1'b0);
            check_flag($sformatf("m%0d_arready", i + 1), m_arready[i], 1'b0);
            check_flag($sformatf("m%0d_rvalid", i + 1), m_rvalid[i], 1'b0);
        end
        check_grant_idle("grant_s1", uut.grant_s1);
        check_grant_idle("grant_s2", uut.grant_s2);
        report_test("reset_state", e0);
    endtask

    task automatic test_read_s1();
        int e0;
        e0 = errors;
        run_read(0, 0, 32'h0000_0100, 32'h0000_0100, 8'h11, 8'd3, 1'b0);
        check_grant_idle("grant_s1", uut.grant_s1);
        report_test("read_s1", e0);
    endtask

    task automatic test_read_s2();
        int e0;
        e0 = errors;
        run_read(1, 1, 32'h8000_0040, 32'h0000_0040, 8'h22, 8'd2, 1'b0);
        check_grant_idle("grant_s2", uut.grant_s2);
        report_test("read_s2", e0);
    endtask

    task automatic test_parallel();
        int e0;
        e0 = errors;
        fork
            run_read(0, 0, 32'h0000_0300, 32'h0000_0300, 8'h31, 8'd4, 1'b0);
            run_read(1, 1, 32'h9000_0010, 32'h1000_0010, 8'h32, 8'd4, 1'b0);
        join
        check_grant_idle("grant_s1", uut.grant_s1);
        check_grant_idle("grant_s2", uut.grant_s2);
        report_test("parallel", e0);
    endtask

    task automatic test_contention();
        int e0;
        e0 = errors;
        fork
            run_read(0, 0, 32'h0000_0400, 32'h0000_0400, 8'h41, 8'd2, 1'b0);
            run_read(1, 0, 32'h0000_0500, 32'h0000_0500, 8'h42, 8'd2, 1'b0);
        join
        check_order("m2 got the address phase before m1 finished", ar_time[1] > done_time[0]);
        // Second round goes to the master that lost the first
        fork
            run_read(0, 0, 32'h0000_0600, 32'h0000_0600, 8'h43, 8'd1, 1'b0);
            run_read(1, 0, 32'h0000_0700, 32'h0000_0700, 8'h44, 8'd1, 1'b0);
        join
        check_order("m1 got the address phase before m2 finished", ar_time[0] > done_time[1]);
        check_grant_idle("grant_s1", uut.grant_s1);
        report_test("contention", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = errors;
        run_read(0, 0, 32'h0000_0800, 32'h0000_0800, 8'h51, 8'd7, 1'b1);
        check_grant_idle("grant_s1", uut.grant_s1);
        report_test("backpressure", e0);
    endtask

    initial begin
        int total;
        void'($urandom(51));
        cycles    = 0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        rst       = 1'b1;
        for (int i = 0; i < 2; i++) begin
            m_arvalid[i] = 1'b0;
            m_araddr[i]  = '0;
            m_arid[i]    = '0;
            m_arlen[i]   = '0;
            m_rready[i]  = 1'b0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_read_s1();
        test_read_s2();
        test_parallel();
        test_contention();
        test_backpressure();
        total = errors + uut.props.assert_fails;
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/axi_pkg.sv
rtl/xbar_map_pkg.sv
rtl/ar_addr_decoder.sv
rtl/read_arbiter.sv
rtl/channel_mux.sv
rtl/axi_read_xbar.sv
tests/axi_read_xbar_props.sv
tests/tb_axi_read_xbar.sv

// ==== Bender.yml ====
package:
  name: axi_read_xbar

sources:
  - rtl/axi_pkg.sv
  - rtl/xbar_map_pkg.sv
  - rtl/ar_addr_decoder.sv
  - rtl/read_arbiter.sv
  - rtl/channel_mux.sv
  - rtl/axi_read_xbar.sv
  - target: test
    files:
      - tests/axi_read_xbar_props.sv
      - tests/tb_axi_read_xbar.sv
